// ==== ts_if_pkg.sv ====
`default_nettype none

package ts_if_pkg;

	//////////////////////
	// mode and size types
	//////////////////////

	typedef struct packed {
		logic [1:0] srrc_mode;  // roll-off, 00 0.35 / 01 0.25 / 10 0.20
		logic [1:0] mod_mode;   // qpsk, 8psk, 16apsk, 32apsk
		logic [3:0] ldpc_mode;  // code rate index
		logic       frame_mode; // 1 = short fecframe
		logic       pilot_mode; // pilots on
	} mode_cfg_t;

	typedef struct packed {
		logic [12:0] ts_bytes; // ts bytes carried per frame
		logic [15:0] pl_bytes; // pl symbols per frame, in byte units
	} frame_size_t;

	typedef logic [7:0] ts_byte_t;

	//////////////////////
	// bbheader constants
	//////////////////////

	localparam logic [5:0]  MATYPE_HI = 6'b111100;  // ts, sis, ccm, issyi off, npd off
	localparam logic [15:0] UPL_BYTES = 16'h05E0;   // 188 * 8 bits
	localparam ts_byte_t    SYNC_BYTE = 8'h47;      // mpeg-2 sync
	localparam ts_byte_t    CRC8_POLY = 8'hD5;      // x^8 term implied
	localparam int          HDR_LEN   = 9;          // bytes ahead of the crc

	// one bit per header byte, idle in bit 0
	typedef enum logic [9:0] {
		HDR_IDLE    = 10'b00_0000_0001,
		HDR_MATYPE1 = 10'b00_0000_0010,
		HDR_MATYPE2 = 10'b00_0000_0100,
		HDR_UPL1    = 10'b00_0000_1000,
		HDR_UPL2    = 10'b00_0001_0000,
		HDR_DFL1    = 10'b00_0010_0000,
		HDR_DFL2    = 10'b00_0100_0000,
		HDR_SYNC    = 10'b00_1000_0000,
		HDR_SYNCD1  = 10'b01_0000_0000,
		HDR_SYNCD2  = 10'b10_0000_0000
	} hdr_state_e;

endpackage

`default_nettype wire

// ==== frame_size_table.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_size_table
	import ts_if_pkg::*;
(
	input  wire        sys_clk,
	input  wire        glb_rst_n,
	input  mode_cfg_t  mode,
	output frame_size_t sizes
);

	always_ff @(posedge sys_clk) begin
		if (!glb_rst_n) begin
			sizes <= '0;
		end else begin
			////////////////////
			// ts bytes = (kbch - 80) / 8
			////////////////////
			case ({mode.frame_mode, mode.ldpc_mode})
				5'h00: sizes.ts_bytes <= 13'd1991; // normal 1/4
				5'h01: sizes.ts_bytes <= 13'd2666; // 1/3
				5'h02: sizes.ts_bytes <= 13'd3206; // 2/5
				5'h03: sizes.ts_bytes <= 13'd4016; // 1/2
				5'h04: sizes.ts_bytes <= 13'd4826; // 3/5
				5'h05: sizes.ts_bytes <= 13'd5370; // 2/3
				5'h06: sizes.ts_bytes <= 13'd6041; // 3/4
				5'h07: sizes.ts_bytes <= 13'd6446; // 4/5
				5'h08: sizes.ts_bytes <= 13'd6720; // 5/6
				5'h09: sizes.ts_bytes <= 13'd7174; // 8/9
				5'h0a: sizes.ts_bytes <= 13'd7264; // 9/10
				5'h10: sizes.ts_bytes <= 13'd374;  // short 1/4
				5'h11: sizes.ts_bytes <= 13'd644;  // 1/3
				5'h12: sizes.ts_bytes <= 13'd779;  // 2/5
				5'h13: sizes.ts_bytes <= 13'd869;  // 1/2
				5'h14: sizes.ts_bytes <= 13'd1184; // 3/5
				5'h15: sizes.ts_bytes <= 13'd1319; // 2/3
				5'h16: sizes.ts_bytes <= 13'd1454; // 3/4
				5'h17: sizes.ts_bytes <= 13'd1544; // 4/5
				5'h18: sizes.ts_bytes <= 13'd1634; // 5/6
				5'h19: sizes.ts_bytes <= 13'd1769; // 8/9
				// short 9/10 does not exist
				default: sizes.ts_bytes <= 13'd0;
			endcase

			////////////////////
			// pl length incl plheader and pilots
			////////////////////
			case ({mode.frame_mode, mode.pilot_mode, mode.mod_mode})
				4'h0: sizes.pl_bytes <= 16'd32490; // normal, no pilots, qpsk
				4'h1: sizes.pl_bytes <= 16'd21690; // 8psk
				4'h2: sizes.pl_bytes <= 16'd16290; // 16apsk
				4'h3: sizes.pl_bytes <= 16'd13050; // 32apsk
				4'h4: sizes.pl_bytes <= 16'd33282; // normal with pilots
				4'h5: sizes.pl_bytes <= 16'd22194;
				4'h6: sizes.pl_bytes <= 16'd16686;
				4'h7: sizes.pl_bytes <= 16'd13338;
				4'h8: sizes.pl_bytes <= 16'd8190;  // short, no pilots
				4'h9: sizes.pl_bytes <= 16'd5490;
				4'ha: sizes.pl_bytes <= 16'd4140;
				4'hb: sizes.pl_bytes <= 16'd3330;
				4'hc: sizes.pl_bytes <= 16'd8370;  // short with pilots
				4'hd: sizes.pl_bytes <= 16'd5598;
				4'he: sizes.pl_bytes <= 16'd4212;
				default: sizes.pl_bytes <= 16'd3402;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== crc8_calc.sv ====
`timescale 1ns/10ps
`default_nettype none

module crc8_calc
	import ts_if_pkg::*;
(
	input  wire      sys_clk,
	input  wire      glb_rst_n,
	input  logic     crc_clr,  // frame head, already qualified by fs_en
	input  logic     crc_en,   // header byte strobe
	input  ts_byte_t hdr_byte,
	output ts_byte_t crc
);

	// fold one byte in, msb first
	function automatic ts_byte_t crc8_byte(input ts_byte_t cur, input ts_byte_t din);
		ts_byte_t r;
		logic     fb;
		r = cur;
		for (int i = 7; i >= 0; i--) begin
			fb = r[7] ^ din[i];   // feedback bit
			r  = {r[6:0], 1'b0};
			if (fb) begin
				r = r ^ CRC8_POLY;
			end
		end
		return r;
	endfunction

	always_ff @(posedge sys_clk) begin
		if (!glb_rst_n) begin
			crc <= '0;
		end else if (crc_clr) begin
			crc <= '0;                    // new header
		end else if (crc_en) begin
			crc <= crc8_byte(crc, hdr_byte);
		end
	end

endmodule

`default_nettype wire

// ==== bbheader_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module bbheader_gen
	import ts_if_pkg::*;
(
	input  wire         sys_clk,
	input  wire         glb_rst_n,
	input  wire         fs_en,
	input  wire         bbscramb_frame_vld,
	input  wire  [1:0]  srrc_mode,
	input  frame_size_t sizes,
	input  ts_byte_t    crc,
	output logic        crc_clr,
	output logic        crc_en,
	output ts_byte_t    hdr_byte,
	output logic        ts_byte_en,
	output ts_byte_t    ts_byte_in
);

	localparam int HEAD_TAP = 7;                 // rising edge seen here
	localparam int END_TAP  = HEAD_TAP + HDR_LEN; // window closes here

	logic [END_TAP:1] vld_dly;   // frame valid, one stage per strobe
	logic             hdr_head;  // one strobe, clears crc
	logic             hdr_syn_pre;
	logic             hdr_syn;   // header byte window
	logic             hdr_win_q; // window seen on last strobe
	hdr_state_e       hdr_state;
	logic [15:0]      dfl;       // data field length in bits

	assign dfl = {sizes.ts_bytes, 3'b000};

	////////////////////
	// frame start detect
	////////////////////
	always_ff @(posedge sys_clk) begin
		if (!glb_rst_n) begin
			vld_dly     <= '0;
			hdr_head    <= 1'b0;
			hdr_syn_pre <= 1'b0;
			hdr_syn     <= 1'b0;
		end else if (fs_en) begin
			vld_dly     <= {vld_dly[END_TAP-1:1], bbscramb_frame_vld};
			hdr_head    <= vld_dly[HEAD_TAP] && !vld_dly[HEAD_TAP+1];
			hdr_syn_pre <= vld_dly[HEAD_TAP] && !vld_dly[END_TAP]; // HDR_LEN strobes wide
			hdr_syn     <= hdr_syn_pre;
		end
	end

	assign crc_clr = hdr_head && fs_en;
	assign crc_en  = hdr_syn && fs_en;

	////////////////////
	// header byte sequence
	////////////////////
	always_ff @(posedge sys_clk) begin
		if (!glb_rst_n) begin
			hdr_state <= HDR_IDLE;
			hdr_byte  <= '0;
		end else if (fs_en) begin
			case (hdr_state)
				HDR_IDLE: begin
					if (hdr_syn_pre) begin
						hdr_state <= HDR_MATYPE1;
						hdr_byte  <= {MATYPE_HI, srrc_mode};
					end else begin
						hdr_byte  <= '0;
					end
				end
				HDR_MATYPE1: begin
					hdr_state <= HDR_MATYPE2;
					hdr_byte  <= '0;              // matype2, no isi
				end
				HDR_MATYPE2: begin
					hdr_state <= HDR_UPL1;
					hdr_byte  <= UPL_BYTES[15:8];
				end
				HDR_UPL1: begin
					hdr_state <= HDR_UPL2;
					hdr_byte  <= UPL_BYTES[7:0];
				end
				HDR_UPL2: begin
					hdr_state <= HDR_DFL1;
					hdr_byte  <= dfl[15:8];
				end
				HDR_DFL1: begin
					hdr_state <= HDR_DFL2;
					hdr_byte  <= dfl[7:0];
				end
				HDR_DFL2: begin
					hdr_state <= HDR_SYNC;
					hdr_byte  <= SYNC_BYTE;
				end
				HDR_SYNC: begin
					hdr_state <= HDR_SYNCD1;
					hdr_byte  <= '0;              // syncd always 0 here
				end
				HDR_SYNCD1: begin
					hdr_state <= HDR_SYNCD2;
					hdr_byte  <= '0;
				end
				HDR_SYNCD2: begin
					hdr_state <= HDR_IDLE;
					hdr_byte  <= '0;
				end
				default: begin
					hdr_state <= HDR_IDLE;
					hdr_byte  <= '0;
				end
			endcase
		end
	end

	////////////////////
	// output byte register
	////////////////////
	always_ff @(posedge sys_clk) begin
		if (!glb_rst_n) begin
			hdr_win_q  <= 1'b0;
			ts_byte_en <= 1'b0;
			ts_byte_in <= '0;
		end else if (fs_en) begin
			hdr_win_q <= hdr_syn;
			if (hdr_syn) begin
				ts_byte_en <= 1'b1;
				ts_byte_in <= hdr_byte;   // nine header bytes
			end else if (hdr_win_q) begin
				ts_byte_en <= 1'b1;
				ts_byte_in <= crc;        // crc once, right after window
			end else begin
				ts_byte_en <= 1'b0;
				ts_byte_in <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== ts_rate_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module ts_rate_gen
	import ts_if_pkg::*;
#(
	parameter int TS_CLK_LAT = 8,  // pulse to ts_clk delay
	parameter int RDY_LAT    = 7   // settle stages after step/period
)(
	input  wire         sys_clk,
	input  wire         glb_rst_n,
	input  frame_size_t sizes,
	input  wire  [31:0] sys_baud_num,
	input  wire  [31:0] sys_freq_num,
	output logic        ts_clk
);

	logic [31:0]           step;      // ts bytes * baud
	logic [31:0]           period;    // pl bytes * clock
	logic                  rdy_q;
	logic [RDY_LAT-1:0]    rdy_dly;
	logic                  ready;
	logic [31:0]           phase;
	logic [32:0]           phase_sum; // one spare bit against overflow
	logic                  wrap;
	logic                  wrap_pulse;
	logic [TS_CLK_LAT-1:0] clk_dly;

	////////////////////
	// step, period and ready
	////////////////////
	always_ff @(posedge sys_clk) begin
		if (!glb_rst_n) begin
			step    <= '0;
			period  <= '0;
			rdy_q   <= 1'b0;
			rdy_dly <= '0;
		end else begin
			step    <= 32'(sizes.ts_bytes) * sys_baud_num;
			period  <= 32'(sizes.pl_bytes) * sys_freq_num;
			rdy_q   <= 1'b1;
			rdy_dly <= {rdy_dly[RDY_LAT-2:0], rdy_q}; // wait for products to settle
		end
	end

	assign ready = rdy_dly[RDY_LAT-1];

	////////////////////
	// modulo phase accumulator
	////////////////////
	assign phase_sum = {1'b0, phase} + {1'b0, step};
	assign wrap      = ready && (phase_sum >= {1'b0, period});

	always_ff @(posedge sys_clk) begin
		if (!glb_rst_n) begin
			phase      <= '0;
			wrap_pulse <= 1'b0;
		end else begin
			wrap_pulse <= wrap;
			if (!ready) begin
				phase <= '0;                           // hold until settled
			end else if (wrap) begin
				phase <= 32'(phase_sum - {1'b0, period});
			end else begin
				phase <= phase_sum[31:0];
			end
		end
	end

	// ts_clk lags the wrap pulse
	always_ff @(posedge sys_clk) begin
		if (!glb_rst_n) begin
			clk_dly <= '0;
		end else begin
			clk_dly <= {clk_dly[TS_CLK_LAT-2:0], wrap_pulse};
		end
	end

	assign ts_clk = clk_dly[TS_CLK_LAT-1];

endmodule

`default_nettype wire

// ==== ts_interface.sv ====
`timescale 1ns/10ps
`default_nettype none

module ts_interface
	import ts_if_pkg::*;
#(
	parameter int TS_CLK_LAT = 8,
	parameter int RDY_LAT    = 7
)(
	input  wire         sys_clk,
	input  wire         glb_rst_n,
	input  wire         fs_en,               // symbol strobe
	input  wire         bbscramb_frame_vld,
	input  mode_cfg_t   mode,
	input  wire  [31:0] sys_baud_num,
	input  wire  [31:0] sys_freq_num,        // 10000 for 100 MHz
	output logic        ts_byte_en,
	output ts_byte_t    ts_byte_in,
	output logic        ts_clk
);

	frame_size_t sizes;
	logic        crc_clr;
	logic        crc_en;
	ts_byte_t    hdr_byte;
	ts_byte_t    crc;

	// per-frame sizes from the mode word
	frame_size_table u_frame_size_table (
		.sys_clk   (sys_clk),
		.glb_rst_n (glb_rst_n),
		.mode      (mode),
		.sizes     (sizes)
	);

	bbheader_gen u_bbheader_gen (
		.sys_clk            (sys_clk),
		.glb_rst_n          (glb_rst_n),
		.fs_en              (fs_en),
		.bbscramb_frame_vld (bbscramb_frame_vld),
		.srrc_mode          (mode.srrc_mode),
		.sizes              (sizes),
		.crc                (crc),
		.crc_clr            (crc_clr),
		.crc_en             (crc_en),
		.hdr_byte           (hdr_byte),
		.ts_byte_en         (ts_byte_en),
		.ts_byte_in         (ts_byte_in)
	);

	crc8_calc u_crc8_calc (
		.sys_clk   (sys_clk),
		.glb_rst_n (glb_rst_n),
		.crc_clr   (crc_clr),
		.crc_en    (crc_en),
		.hdr_byte  (hdr_byte),
		.crc       (crc)
	);

	// ts byte clock from the frame-size ratio
	ts_rate_gen #(
		.TS_CLK_LAT (TS_CLK_LAT),
		.RDY_LAT    (RDY_LAT)
	) u_ts_rate_gen (
		.sys_clk      (sys_clk),
		.glb_rst_n    (glb_rst_n),
		.sizes        (sizes),
		.sys_baud_num (sys_baud_num),
		.sys_freq_num (sys_freq_num),
		.ts_clk       (ts_clk)
	);

endmodule

`default_nettype wire

// ==== ts_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module ts_checker
	import ts_if_pkg::*;
#(
	parameter int N_FRAMES = 1
)(
	input  wire         sys_clk,
	input  wire         glb_rst_n,
	input  wire         fs_en,
	input  wire         bbscramb_frame_vld,
	input  mode_cfg_t   mode,
	input  wire  [31:0] sys_baud_num,
	input  wire  [31:0] sys_freq_num,
	input  wire         ts_byte_en,
	input  ts_byte_t    ts_byte_in,
	input  wire         ts_clk,
	input  wire  [12:0] exp_ts_bytes,
	input  wire  [15:0] exp_pl_bytes,
	input  wire         rate_win,
	input  wire         run_done,
	output int          errors
);

	logic            fs_q;       // strobe seen by the DUT at the last edge
	logic            en_q;
	ts_byte_t        byte_q;
	logic            win_q;
	logic            done_q;
	logic            vld_seen;   // first frame start reached
	int              rst_seen;
	int              since_rst;
	int              idx;        // byte index in current header
	int              frames;
	ts_byte_t        exp_hdr [0:8];
	ts_byte_t        exp_b;
	longint unsigned win_cyc;
	longint unsigned win_pulses;
	longint unsigned win_step;
	longint unsigned win_period;
	longint unsigned exp_cnt;

	// bit-serial crc-8 over 72 bits with poly x^8+x^7+x^6+x^4+x^2+1
	function automatic ts_byte_t crc8_ref(input logic [71:0] msg);
		ts_byte_t r;
		logic     top;
		r = 8'h00;
		for (int i = 71; i >= 0; i--) begin
			top = r[7] ^ msg[i];
			r   = r << 1;
			if (top) r = r ^ 8'hD5;
		end
		return r;
	endfunction

	// header byte k from the frame rules
	function automatic ts_byte_t hdr_expect(input int k, input logic [1:0] srrc,
			input logic [12:0] tsb);
		logic [15:0] dfl;
		dfl = 16'(tsb) * 16'd8;   // bits per data field
		case (k)
			0:       return {6'b111100, srrc};
			2:       return 8'h05;          // upl 188*8
			3:       return 8'hE0;
			4:       return dfl[15:8];
			5:       return dfl[7:0];
			6:       return 8'h47;
			default: return 8'h00;          // matype2 and syncd
		endcase
	endfunction

	initial begin
		errors     = 0;
		rst_seen   = 0;
		since_rst  = 0;
		idx        = 0;
		frames     = 0;
		fs_q       = 0;
		en_q       = 0;
		byte_q     = 0;
		win_q      = 0;
		done_q     = 0;
		vld_seen   = 0;
		win_cyc    = 0;
		win_pulses = 0;
		win_step   = 0;
		win_period = 0;
	end

	always @(negedge sys_clk) begin
		if (!glb_rst_n) begin
			if (rst_seen >= 2 && {ts_byte_en, ts_byte_in, ts_clk} !== 10'h000) begin
				$display("outputs not cleared during reset at %0t", $time);
				errors++;
			end
			rst_seen++;
			since_rst = 0;
			idx       = 0;
		end else begin
			since_rst++;
			if (since_rst <= 8 && ts_clk !== 1'b0) begin
				$display("ts_clk pulsed %0d cycles after reset release", since_rst);
				errors++;
			end
			if (!vld_seen && ts_clk !== 1'b0) begin
				$display("ts_clk pulsed before the first frame start at %0t", $time);
				errors++;
			end
			if ($isunknown({ts_byte_en, ts_byte_in, ts_clk})) begin
				$display("unknown value on DUT outputs at %0t", $time);
				errors++;
			end
			if (!fs_q) begin
				// outputs hold without a strobe
				if (ts_byte_en !== en_q) begin
					$display("Mismatch ts_byte_en (hold): expected %h, got %h", en_q, ts_byte_en);
					errors++;
				end
				if (ts_byte_in !== byte_q) begin
					$display("Mismatch ts_byte_in (hold): expected %02h, got %02h",
						byte_q, ts_byte_in);
					errors++;
				end
			end else if (ts_byte_en === 1'b1) begin
				if (idx >= 10) begin
					$display("more than ten header bytes in frame %0d", frames);
					errors++;
				end else begin
					if (idx < 9) begin
						exp_b        = hdr_expect(idx, mode.srrc_mode, exp_ts_bytes);
						exp_hdr[idx] = exp_b;
					end else begin
						exp_b = crc8_ref({exp_hdr[0], exp_hdr[1], exp_hdr[2], exp_hdr[3],
							exp_hdr[4], exp_hdr[5], exp_hdr[6], exp_hdr[7], exp_hdr[8]});
					end
					if (ts_byte_in !== exp_b) begin
						$display("Mismatch ts_byte_in (frame %0d byte %0d): expected %02h, got %02h",
							frames, idx, exp_b, ts_byte_in);
						errors++;
					end
				end
				idx++;
			end else if (idx != 0) begin
				if (idx != 10) begin
					$display("frame %0d ended after %0d bytes instead of ten", frames, idx);
					errors++;
				end
				frames++;
				idx = 0;
			end
			if (ts_byte_en === 1'b0 && ts_byte_in !== 8'h00) begin
				$display("Mismatch ts_byte_in (idle): expected 00, got %02h", ts_byte_in);
				errors++;
			end

			////////////////////
			// ts_clk rate window
			////////////////////
			if (rate_win && !win_q) begin
				win_step   = exp_ts_bytes;
				win_step   = win_step * sys_baud_num;
				win_period = exp_pl_bytes;
				win_period = win_period * sys_freq_num;
			end
			if (rate_win) begin
				win_cyc++;
				if (ts_clk === 1'b1) win_pulses++;
			end else if (win_q) begin
				exp_cnt = (win_cyc * win_step) / win_period;   // floor
				if ((win_step == 0 && win_pulses != 0) ||
						win_pulses > exp_cnt + 1 || win_pulses + 1 < exp_cnt) begin
					$display("Mismatch ts_clk count over %0d cycles: expected %h, got %h",
						win_cyc, exp_cnt, win_pulses);
					errors++;
				end
				win_cyc    = 0;
				win_pulses = 0;
			end
		end
		if (run_done && !done_q) begin
			if (frames != N_FRAMES || idx != 0) begin
				$display("saw %0d complete headers, expected %0d", frames, N_FRAMES);
				errors++;
			end
		end
		if (glb_rst_n && bbscramb_frame_vld) begin
			vld_seen = 1;
		end
		fs_q   = fs_en;
		en_q   = ts_byte_en;
		byte_q = ts_byte_in;
		win_q  = rate_win;
		done_q = run_done;
	end

endmodule

`default_nettype wire

// ==== tb_ts_interface.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_ts_interface
	import ts_if_pkg::*;
();

	localparam int N_ENTRIES    = 7;
	localparam int RATE_WIN     = 2000;  // cycles per rate window
	localparam int RST_CYC      = 16;
	localparam int WATCHDOG_CYC = N_ENTRIES * (64 * 3 + RATE_WIN) + 4 * RST_CYC;

	// one row of the stimulus table
	typedef struct packed {
		mode_cfg_t   mode;
		logic [31:0] baud;
		logic [31:0] freq;
		logic [12:0] ts_bytes; // expected table output
		logic [15:0] pl_bytes;
	} stim_t;

	logic        sys_clk;
	logic        glb_rst_n;
	logic        fs_en;
	logic        bbscramb_frame_vld;
	mode_cfg_t   mode;
	logic [31:0] sys_baud_num;
	logic [31:0] sys_freq_num;
	logic        ts_byte_en;
	ts_byte_t    ts_byte_in;
	logic        ts_clk;
	logic [12:0] exp_ts_bytes;
	logic [15:0] exp_pl_bytes;
	logic        rate_win;   // checker counts ts_clk while high
	logic        run_done;
	int          chk_errors;
	integer      seed;
	stim_t       stim [N_ENTRIES];

	ts_interface #(
		.TS_CLK_LAT (8),
		.RDY_LAT    (7)
	) UUT (
		.sys_clk            (sys_clk),
		.glb_rst_n          (glb_rst_n),
		.fs_en              (fs_en),
		.bbscramb_frame_vld (bbscramb_frame_vld),
		.mode               (mode),
		.sys_baud_num       (sys_baud_num),
		.sys_freq_num       (sys_freq_num),
		.ts_byte_en         (ts_byte_en),
		.ts_byte_in         (ts_byte_in),
		.ts_clk             (ts_clk)
	);

	ts_checker #(
		.N_FRAMES (N_ENTRIES)
	) u_checker (
		.sys_clk            (sys_clk),
		.glb_rst_n          (glb_rst_n),
		.fs_en              (fs_en),
		.bbscramb_frame_vld (bbscramb_frame_vld),
		.mode               (mode),
		.sys_baud_num       (sys_baud_num),
		.sys_freq_num       (sys_freq_num),
		.ts_byte_en         (ts_byte_en),
		.ts_byte_in         (ts_byte_in),
		.ts_clk             (ts_clk),
		.exp_ts_bytes       (exp_ts_bytes),
		.exp_pl_bytes       (exp_pl_bytes),
		.rate_win           (rate_win),
		.run_done           (run_done),
		.errors             (chk_errors)
	);

	initial sys_clk = 1'b0;
	always #20 sys_clk = ~sys_clk;  // 40 ns period

	// symbol strobe about one cycle in two
	always @(posedge sys_clk) begin
		fs_en <= ($random(seed) % 2) != 0;
	end

	function automatic stim_t make_entry(input logic [1:0] srrc, input logic [1:0] modu,
			input logic [3:0] ldpc, input logic short_fr, input logic pilots,
			input logic [31:0] baud, input logic [31:0] freq,
			input logic [12:0] ts_b, input logic [15:0] pl_b);
		stim_t s;
		s.mode     = '{srrc, modu, ldpc, short_fr, pilots};
		s.baud     = baud;
		s.freq     = freq;
		s.ts_bytes = ts_b;
		s.pl_bytes = pl_b;
		return s;
	endfunction

	// count edges on which the DUT sees a strobe
	task automatic wait_strobes(input int n);
		int seen;
		seen = 0;
		while (seen < n) begin
			@(posedge sys_clk);
			if (fs_en) seen++;
		end
	endtask

	task automatic apply_entry(input stim_t s);
		@(posedge sys_clk);
		mode         <= s.mode;
		sys_baud_num <= s.baud;
		sys_freq_num <= s.freq;
		exp_ts_bytes <= s.ts_bytes;
		exp_pl_bytes <= s.pl_bytes;
	endtask

	task automatic run_frame();
		bbscramb_frame_vld <= 1'b1;
		wait_strobes(12);
		bbscramb_frame_vld <= 1'b0;
		wait_strobes(20);   // gap with the header long done
	endtask

	task automatic measure_rate();
		rate_win <= 1'b1;
		repeat (RATE_WIN) @(posedge sys_clk);
		rate_win <= 1'b0;
		@(posedge sys_clk);
	endtask

	////////////////////
	// main sequence
	////////////////////
	initial begin
		seed               = 46;
		glb_rst_n          = 1'b0;
		fs_en              = 1'b0;
		bbscramb_frame_vld = 1'b0;
		mode               = '0;
		sys_baud_num       = '0;   // no ts_clk until first entry
		sys_freq_num       = 32'd10000;
		exp_ts_bytes       = '0;
		exp_pl_bytes       = '0;
		rate_win           = 1'b0;
		run_done           = 1'b0;
		// srrc mod ldpc short pilot baud freq ts pl
		stim[0] = make_entry(2'd0, 2'd0, 4'd3, 1'b0, 1'b0, 20000, 10000, 13'd4016, 16'd32490);
		stim[1] = make_entry(2'd1, 2'd1, 4'd5, 1'b0, 1'b1, 15000, 10000, 13'd5370, 16'd22194);
		stim[2] = make_entry(2'd2, 2'd2, 4'd8, 1'b1, 1'b0, 9000, 10000, 13'd1634, 16'd4140);
		stim[3] = make_entry(2'd0, 2'd3, 4'd10, 1'b0, 1'b1, 12000, 10000, 13'd7264, 16'd13338);
		stim[4] = make_entry(2'd1, 2'd0, 4'd10, 1'b1, 1'b1, 20000, 10000, 13'd0, 16'd8370);
		stim[5] = make_entry(2'd2, 2'd1, 4'd0, 1'b1, 1'b0, 30000, 10000, 13'd374, 16'd5490);
		stim[6] = make_entry(2'd3, 2'd2, 4'd0, 1'b0, 1'b0, 40000, 10000, 13'd1991, 16'd16290);

		repeat (RST_CYC) @(posedge sys_clk);
		glb_rst_n <= 1'b1;
		repeat (RST_CYC) @(posedge sys_clk);  // rate ready flag settles

		for (int i = 0; i < N_ENTRIES; i++) begin
			apply_entry(stim[i]);
			run_frame();
			measure_rate();
		end

		run_done <= 1'b1;
		repeat (2) @(posedge sys_clk);
		$display("errors: %0d", chk_errors);
		if (chk_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		repeat (WATCHDOG_CYC) @(posedge sys_clk);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYC);
		$display("errors: %0d", chk_errors);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
ts_if_pkg.sv
frame_size_table.sv
crc8_calc.sv
bbheader_gen.sv
ts_rate_gen.sv
ts_interface.sv
ts_checker.sv
tb_ts_interface.sv

// ==== Bender.yml ====
package:
  name: ts_interface

sources:
  - ts_if_pkg.sv
  - frame_size_table.sv
  - crc8_calc.sv
  - bbheader_gen.sv
  - ts_rate_gen.sv
  - ts_interface.sv
  - target: test
    files:
      - ts_checker.sv
      - tb_ts_interface.sv
